// ==== rtl/crc_pkg.sv ====
// shared constants for the CRC-16 accelerator, imported by every RTL module
package crc_pkg;

    // checksum
    localparam int crc_width = 16;

    // CCITT generator, MSB-first shift with LSB-first data bits
    localparam logic [crc_width-1:0] crc_poly = 16'h1021;

    // value after reset and after a CTRL init
    localparam logic [crc_width-1:0] crc_seed = 16'hFFFF;

    localparam int byte_width = 8;

    // AXI4-Lite slave port
    localparam int axil_addr_width = 4;
    localparam int axil_data_width = 32;

    // register map, byte offsets

    // bit 0 set on write re-seeds the checksum
    localparam logic [axil_addr_width-1:0] reg_ctrl = 4'h0;

    // low byte of write data goes to the engine
    localparam logic [axil_addr_width-1:0] reg_data = 4'h4;

    // read only, checksum in bits 15:0
    localparam logic [axil_addr_width-1:0] reg_crc = 4'h8;

    // read only, bit 0 is busy
    localparam logic [axil_addr_width-1:0] reg_status = 4'hC;

endpackage

// ==== rtl/crc_bit_engine.sv ====
// bit-serial CRC-16 engine, folds one byte per start pulse over eight clocks
`timescale 1ns/1ps

module crc_bit_engine (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           init,
    input  logic                           start,
    input  logic [crc_pkg::byte_width-1:0] data,
    output logic                           ready,
    output logic [crc_pkg::crc_width-1:0]  crc,
    output logic                           done
);
    import crc_pkg::*;

    // running value while a byte is being shifted in
    logic [crc_width-1:0]  work;
    logic [crc_width-1:0]  work_next;
    logic [byte_width-1:0] byte_q;
    logic [2:0]            bit_cnt;
    logic                  busy;

    // one step of the shift register for a single entering bit
    function automatic logic [crc_width-1:0] crc_step(
        input logic [crc_width-1:0] cur,
        input logic                 din
    );
        logic [crc_width-1:0] shifted;
        shifted = {cur[crc_width-2:0], 1'b0};
        if ((din ^ cur[crc_width-1]) == 1'b1) begin
            crc_step = shifted ^ crc_poly;
        end else begin
            crc_step = shifted;
        end
    endfunction

    // lsb of the byte enters first
    always_comb begin
        work_next = crc_step(work, byte_q[bit_cnt]);
    end

    assign ready = !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
            crc     <= crc_seed;
        end else begin
            done <= 1'b0;
            if (init) begin
                crc <= crc_seed;
            end else if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                if (bit_cnt == 3'(byte_width - 1)) begin
                    // last bit goes straight into the committed value
                    crc  <= work_next;
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
            end
        end
    end

    // working copy starts from the committed checksum
    always_ff @(posedge clk) begin
        if (start) begin
            work   <= crc;
            byte_q <= data;
        end else if (busy) begin
            work <= work_next;
        end
    end

    // the register block must hold off requests while a byte is in flight
    a_req_when_ready : assert property (
        @(posedge clk) disable iff (rst)
        (start || init) |-> ready
    );

    // back-to-back bytes still leave a gap of eight clocks
    a_done_single : assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

endmodule

// ==== rtl/axil_crc_regs.sv ====
// AXI4-Lite register block, decodes CTRL/DATA/CRC/STATUS and paces bytes into the engine
`timescale 1ns/1ps

module axil_crc_regs (
    input  logic                                clk,
    input  logic                                rst,
    // write address
    input  logic [crc_pkg::axil_addr_width-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    // write data
    input  logic [crc_pkg::axil_data_width-1:0] wdata,
    input  logic                                wvalid,
    output logic                                wready,
    // write response
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    // read address
    input  logic [crc_pkg::axil_addr_width-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    // read data
    output logic [crc_pkg::axil_data_width-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    // engine side
    output logic                                init,
    output logic                                start,
    output logic [crc_pkg::byte_width-1:0]      data,
    input  logic                                ready,
    input  logic [crc_pkg::crc_width-1:0]       crc
);
    import crc_pkg::*;

    logic                       wr_req;
    logic                       wr_ctrl;
    logic                       wr_data;
    logic                       wr_accept;
    logic                       rd_accept;
    logic [axil_data_width-1:0] rd_word;

    // address and data must arrive together, one response outstanding at most
    assign wr_req  = awvalid && wvalid && !bvalid;
    assign wr_ctrl = (awaddr == reg_ctrl);
    assign wr_data = (awaddr == reg_data);

    // CTRL and DATA touch the engine and wait for it to go idle
    assign wr_accept = wr_req && (ready || !(wr_ctrl || wr_data));

    assign awready = wr_accept;
    assign wready  = wr_accept;

    // pulses last exactly the accepting cycle
    assign init  = wr_accept && wr_ctrl && wdata[0];
    assign start = wr_accept && wr_data;
    assign data  = wdata[byte_width-1:0];

    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // reads never wait on the engine
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    always_comb begin
        rd_word = '0;
        case (araddr)
            reg_crc: begin
                rd_word[crc_width-1:0] = crc;
            end
            reg_status: begin
                rd_word[0] = !ready;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // sampled at the address handshake, held while rvalid waits
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_word;
        end
    end

    a_bvalid_hold : assert property (
        @(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid
    );

    a_rvalid_hold : assert property (
        @(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> rvalid
    );

endmodule

// ==== rtl/crc_accel_top.sv ====
// top level of the CRC-16 accelerator, AXI4-Lite slave in front of the bit engine
`timescale 1ns/1ps

module crc_accel_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [crc_pkg::axil_addr_width-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [crc_pkg::axil_data_width-1:0] wdata,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [crc_pkg::axil_addr_width-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [crc_pkg::axil_data_width-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready
);
    import crc_pkg::*;

    logic                  init;
    logic                  start;
    logic [byte_width-1:0] data;
    logic                  ready;
    logic [crc_width-1:0]  crc;
    // byte-complete strobe, visible for debug
    logic                  done;

    axil_crc_regs regs (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .init    (init),
        .start   (start),
        .data    (data),
        .ready   (ready),
        .crc     (crc)
    );

    crc_bit_engine engine (
        .clk   (clk),
        .rst   (rst),
        .init  (init),
        .start (start),
        .data  (data),
        .ready (ready),
        .crc   (crc),
        .done  (done)
    );

endmodule

// ==== bench/crc_accel_tb.sv ====
// testbench for the CRC-16 accelerator, drives AXI4-Lite traffic and checks against a reference model
`timescale 1ns/1ps

module crc_accel_tb;
    import crc_pkg::*;

    // 200 bytes at 40 cycles each, plus margin
    localparam int watchdog_cycles = 200 * 40 + 2000;

    logic                       clk;
    logic                       rst;
    logic [axil_addr_width-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [axil_data_width-1:0] wdata;
    logic                       wvalid;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;
    logic [axil_addr_width-1:0] araddr;
    logic                       arvalid;
    logic                       arready;
    logic [axil_data_width-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;

    int                   errors;
    int                   checks;
    int                   writes_issued;
    int                   reads_issued;
    int                   b_count;
    int                   r_count;
    int                   stall_cycles;
    int                   done_count;
    int                   bytes_sent;
    bit                   quiet;
    logic [crc_width-1:0] model;

    crc_accel_top uut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // response handshakes, write stalls and finished bytes
    always @(posedge clk) begin
        if (!rst) begin
            if (bvalid && bready) begin
                b_count++;
            end
            if (rvalid && rready) begin
                r_count++;
            end
            if (awvalid && !awready) begin
                stall_cycles++;
            end
            if (uut.done) begin
                done_count++;
            end
        end
    end

    // lsb first, shift left, xor poly on feedback
    function automatic logic [crc_width-1:0] fold_byte(
        input logic [crc_width-1:0]  cur,
        input logic [byte_width-1:0] b
    );
        logic [crc_width-1:0] c;
        logic                 fb;
        c = cur;
        for (int i = 0; i < byte_width; i++) begin
            fb = b[i] ^ c[crc_width-1];
            c  = {c[crc_width-2:0], 1'b0};
            if (fb) begin
                c = c ^ 16'h1021;
            end
        end
        return c;
    endfunction

    // sometimes hold bready/rready low for a while
    function automatic int resp_delay();
        if (quiet || ($urandom % 3 != 0)) begin
            return 0;
        end
        return int'($urandom % 6);
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s expected 0x%08h got 0x%08h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic write_reg(input logic [axil_addr_width-1:0] addr, input logic [31:0] value);
        int delay;
        delay = resp_delay();
        writes_issued++;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = value;
        wvalid  = 1'b1;
        do @(posedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (delay) @(negedge clk);
        bready = 1'b1;
        do @(posedge clk); while (!bvalid);
        expect_value("bresp", 32'(bresp), 32'h0);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [axil_addr_width-1:0] addr, output logic [31:0] value);
        int delay;
        delay = resp_delay();
        reads_issued++;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        repeat (delay) @(negedge clk);
        rready = 1'b1;
        do @(posedge clk); while (!rvalid);
        value = rdata;
        expect_value("rresp", 32'(rresp), 32'h0);
        @(negedge clk);
        rready = 1'b0;
    endtask

    // upper data bits are noise, only the low byte counts
    task automatic send_byte(input logic [byte_width-1:0] b);
        logic [31:0] word;
        word = $urandom;
        word[byte_width-1:0] = b;
        write_reg(reg_data, word);
        bytes_sent++;
        model = fold_byte(model, b);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        do read_reg(reg_status, status); while (status != 32'h0);
    endtask

    task automatic check_crc();
        logic [31:0] value;
        read_reg(reg_crc, value);
        expect_value("crc", value, {16'h0, model});
    endtask

    initial begin
        logic [31:0] value;
        int unsigned seed_val;
        int          stalls_before;
        seed_val = $urandom(57412);
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        quiet = 1'b0;
        model = crc_seed;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // state after reset
        expect_value("bvalid", 32'(bvalid), 32'h0);
        expect_value("rvalid", 32'(rvalid), 32'h0);
        read_reg(reg_status, value);
        expect_value("status", value, 32'h0);
        check_crc();

        send_byte(8'h31);
        wait_idle();
        check_crc();

        // random stream, checked every 8th byte
        for (int i = 0; i < 64; i++) begin
            send_byte(8'($urandom));
            if (i % 8 == 7) begin
                wait_idle();
                check_crc();
            end
        end

        // re-seed mid-stream, bit 0 clear does nothing
        for (int i = 0; i < 4; i++) begin
            send_byte(8'($urandom));
        end
        write_reg(reg_ctrl, 32'h0);
        check_crc();
        write_reg(reg_ctrl, 32'h1);
        model = crc_seed;
        check_crc();
        for (int i = 0; i < 8; i++) begin
            send_byte(8'($urandom));
        end
        wait_idle();
        check_crc();

        // second byte lands while the engine is busy
        quiet = 1'b1;
        stalls_before = stall_cycles;
        send_byte(8'hA5);
        fork
            send_byte(8'h5A);
            begin
                read_reg(reg_status, value);
                expect_value("status", value, 32'h1);
            end
        join
        checks++;
        assert (stall_cycles > stalls_before) else begin
            errors++;
            $display("DATA write behind a busy engine was accepted without waiting");
        end
        quiet = 1'b0;
        wait_idle();
        check_crc();

        // read-only and write-only registers
        write_reg(reg_crc, 32'h0000_1234);
        write_reg(reg_status, 32'hFFFF_FFFF);
        read_reg(reg_ctrl, value);
        expect_value("ctrl", value, 32'h0);
        read_reg(reg_data, value);
        expect_value("data", value, 32'h0);
        check_crc();

        repeat (4) @(negedge clk);
        expect_value("b_count", 32'(b_count), 32'(writes_issued));
        expect_value("r_count", 32'(r_count), 32'(reads_issued));
        // one done pulse per byte, none for init
        expect_value("done_count", 32'(done_count), 32'(bytes_sent));
        $display("checks %0d, errors %0d, writes %0d, reads %0d",
                 checks, errors, writes_issued, reads_issued);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, checks %0d, errors %0d",
                 watchdog_cycles, checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    a_aw_w_pair : assert property (@(posedge clk) disable iff (rst) awready == wready)
        else begin
            errors++;
            $display("ERROR wready expected 0x%0h got 0x%0h", awready, wready);
        end

    a_b_single : assert property (@(posedge clk) disable iff (rst) (bvalid && bready) |=> !bvalid)
        else begin
            errors++;
            $display("write response stayed valid after its handshake");
        end

    a_r_single : assert property (@(posedge clk) disable iff (rst) (rvalid && rready) |=> !rvalid)
        else begin
            errors++;
            $display("read response stayed valid after its handshake");
        end

endmodule

// ==== Makefile ====
# Verilator build and run for the CRC-16 accelerator testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := crc_accel_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
rtl/crc_pkg.sv
rtl/crc_bit_engine.sv
rtl/axil_crc_regs.sv
rtl/crc_accel_top.sv
bench/crc_accel_tb.sv
